// ==== Bender.yml ====
package:
  name: dma

sources:
  # Shared packages
  - common/dma_pkg.sv
  - common/wb_pkg.sv
  # Slave side
  - dma_slave/dma_bus_interface.sv
  - dma_slave/dma_request_table.sv
  # Engine, master and top level
  - hdl/dma_transfer_engine.sv
  - hdl/dma_wb_master.sv
  - hdl/dma_top.sv
  # Verification
  - target: test
    files:
      - tests/dma_bus_chk.sv
      - tests/dma_tb.sv

// ==== build.f ====
common/dma_pkg.sv
common/wb_pkg.sv
dma_slave/dma_bus_interface.sv
dma_slave/dma_request_table.sv
hdl/dma_transfer_engine.sv
hdl/dma_wb_master.sv
hdl/dma_top.sv
tests/dma_bus_chk.sv
tests/dma_tb.sv

// ==== common/dma_pkg.sv ====
// DMA descriptor package
// Table entry layout, field offsets, direction and the FSM state encodings
// shared by the slave decoder, the request table, the engine and the master

`default_nettype none

package dma_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Entry fields and descriptor
  ////////////////////////////////////////////////////////////////////////////

  // Copy direction, bit 0 of the control field
  typedef enum logic {
    DIR_REMOTE_TO_LOCAL = 1'b0,
    DIR_LOCAL_TO_REMOTE = 1'b1
  } dma_dir_e;

  // Byte offsets inside one 32-byte entry window
  typedef enum logic [4:0] {
    FIELD_LADDR  = 5'h00,
    FIELD_SIZE   = 5'h04,
    FIELD_RADDR  = 5'h08,
    FIELD_CTRL   = 5'h0C,
    FIELD_STATUS = 5'h14
  } dma_field_e;

  // Entry index, wide enough for 128 entries
  typedef logic [7:0] dma_idx_t;

  // One request, 81 bits
  typedef struct packed {
    logic [31:0] laddr;
    logic [31:0] raddr;
    logic [15:0] size;
    dma_dir_e    dir;
  } dma_req_t;

  // Field write from the slave decoder into the table
  typedef struct packed {
    dma_idx_t    idx;
    dma_field_e  field;
    logic [31:0] data;
    logic        en;
  } dma_field_wr_t;

  ////////////////////////////////////////////////////////////////////////////
  // Engine to master operations and FSM states
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } dma_op_e;

  // Single-word bus operation, req held until done
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    dma_op_e     opcode;
    logic        req;
  } dma_op_t;

  typedef enum logic [2:0] {
    ENG_IDLE,
    ENG_LOAD,
    ENG_READ,
    ENG_WRITE,
    ENG_DONE
  } dma_eng_state_e;

  typedef enum logic {
    MST_IDLE,
    MST_BUSY
  } dma_mst_state_e;

endpackage

`default_nettype wire

// ==== common/wb_pkg.sv ====
// Wishbone classic bus package
// Request and response bundles used on both the slave and the master port

`default_nettype none

package wb_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Classic cycle signals
  ////////////////////////////////////////////////////////////////////////////

  // Master to slave
  // sel is all ones from the master, ignored by the slave
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] adr;
    logic [31:0] dat;
    logic [3:0]  sel;
  } wb_req_t;

  // Slave to master
  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  // Byte lanes for full-word accesses
  localparam logic [3:0] WB_SEL_WORD = 4'hF;

endpackage

`default_nettype wire

// ==== dma_slave/dma_bus_interface.sv ====
// DMA slave bus decoder
// Wishbone classic slave with a registered single-cycle ack; turns writes
// into table field writes and answers status reads from the done vector

`timescale 1ns/1ps
`default_nettype none

module dma_bus_interface #(
  parameter int TABLE_ENTRIES = 4
) (
  input  wire                    clk,
  input  wire                    arst_n_i,
  input  wb_pkg::wb_req_t        wb_req_i,
  output wb_pkg::wb_rsp_t        wb_rsp_o,
  output dma_pkg::dma_field_wr_t field_wr_o,
  input  wire [TABLE_ENTRIES-1:0] done_i
);

  import dma_pkg::*;
  import wb_pkg::*;

  // Entry pointer width, at most 7 bits
  localparam int PTR_W = $clog2(TABLE_ENTRIES);

  ////////////////////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////////////////////

  logic [PTR_W-1:0] entry_ptr;
  dma_field_e       field;
  logic             req_new;
  logic [31:0]      rd_data;
  logic             ack_q;
  logic [31:0]      rdat_q;

  // Entry window is 32 bytes wide
  assign entry_ptr = wb_req_i.adr[PTR_W+4:5];
  assign field     = dma_field_e'(wb_req_i.adr[4:0]);

  // First cycle of a classic request, blocked while ack is out
  assign req_new = wb_req_i.cyc & wb_req_i.stb & ~ack_q;

  // Only status is readable
  always_comb begin
    rd_data = '0;
    if (field == FIELD_STATUS) begin
      rd_data[0] = done_i[entry_ptr];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req_new;
    end
  end

  // Read data sampled on the ack edge
  always_ff @(posedge clk) begin
    if (req_new) begin
      rdat_q <= rd_data;
    end
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.dat = rdat_q;

  // Field write lands on the same edge that raises ack
  assign field_wr_o.idx   = dma_idx_t'(entry_ptr);
  assign field_wr_o.field = field;
  assign field_wr_o.data  = wb_req_i.dat;
  assign field_wr_o.en    = req_new & wb_req_i.we;

endmodule

`default_nettype wire

// ==== dma_slave/dma_request_table.sv ====
// DMA request table
// Descriptor storage with per-entry valid and done flags; presents the
// lowest armed and unfinished entry to the transfer engine

`timescale 1ns/1ps
`default_nettype none

module dma_request_table #(
  parameter int TABLE_ENTRIES = 4
) (
  input  wire                     clk,
  input  wire                     arst_n_i,
  input  dma_pkg::dma_field_wr_t  field_wr_i,
  output logic [TABLE_ENTRIES-1:0] done_o,
  output logic                    pend_o,
  output dma_pkg::dma_idx_t       pend_idx_o,
  output dma_pkg::dma_req_t       pend_req_o,
  input  wire                     complete_i,
  input  dma_pkg::dma_idx_t       complete_idx_i
);

  import dma_pkg::*;

  localparam int PTR_W = $clog2(TABLE_ENTRIES);

  dma_req_t               req_mem [TABLE_ENTRIES];
  logic [TABLE_ENTRIES-1:0] valid_q;
  logic [TABLE_ENTRIES-1:0] done_q;
  logic [PTR_W-1:0]       wr_ptr;
  logic [PTR_W-1:0]       cpl_ptr;
  logic [PTR_W-1:0]       pend_ptr;
  logic                   arm;

  // Upper index bits beyond the table size are ignored
  assign wr_ptr  = field_wr_i.idx[PTR_W-1:0];
  assign cpl_ptr = complete_idx_i[PTR_W-1:0];
  assign arm     = field_wr_i.en & (field_wr_i.field == FIELD_STATUS);

  ////////////////////////////////////////////////////////////////////////////
  // Descriptor fields
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (field_wr_i.en) begin
      case (field_wr_i.field)
        FIELD_LADDR: req_mem[wr_ptr].laddr <= field_wr_i.data;
        FIELD_SIZE:  req_mem[wr_ptr].size  <= field_wr_i.data[15:0];
        FIELD_RADDR: req_mem[wr_ptr].raddr <= field_wr_i.data;
        FIELD_CTRL:  req_mem[wr_ptr].dir   <= dma_dir_e'(field_wr_i.data[0]);
        // Status write only arms, handled with the flags
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Valid and done flags
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= '0;
      done_q  <= '0;
    end else begin
      // Completion retires the entry
      if (complete_i) begin
        valid_q[cpl_ptr] <= 1'b0;
        done_q[cpl_ptr]  <= 1'b1;
      end
      // Arm reopens it; later in the block so it wins on a clash
      if (arm) begin
        valid_q[wr_ptr] <= 1'b1;
        done_q[wr_ptr]  <= 1'b0;
      end
    end
  end

  assign done_o = done_q;

  ////////////////////////////////////////////////////////////////////////////
  // Next pending entry
  ////////////////////////////////////////////////////////////////////////////

  // Scan from the top so the lowest index is assigned last
  always_comb begin
    pend_o   = 1'b0;
    pend_ptr = '0;
    for (int i = TABLE_ENTRIES - 1; i >= 0; i--) begin
      if (valid_q[i] && !done_q[i]) begin
        pend_o   = 1'b1;
        pend_ptr = PTR_W'(i);
      end
    end
  end

  assign pend_idx_o = dma_idx_t'(pend_ptr);
  assign pend_req_o = req_mem[pend_ptr];

endmodule

`default_nettype wire

// ==== hdl/dma_top.sv ====
// DMA top level
// Slave decoder, request table, transfer engine and bus master

`timescale 1ns/1ps
`default_nettype none

module dma_top #(
  parameter int TABLE_ENTRIES = 4
) (
  input  wire             clk,
  input  wire             arst_n_i,
  input  wb_pkg::wb_req_t wbs_req_i,
  output wb_pkg::wb_rsp_t wbs_rsp_o,
  output wb_pkg::wb_req_t wbm_req_o,
  input  wb_pkg::wb_rsp_t wbm_rsp_i,
  output logic            irq_o
);

  import dma_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Internal links
  ////////////////////////////////////////////////////////////////////////////

  dma_field_wr_t            field_wr;
  logic [TABLE_ENTRIES-1:0] done;
  logic                     pend;
  dma_idx_t                 pend_idx;
  dma_req_t                 pend_req;
  logic                     complete;
  dma_idx_t                 complete_idx;
  dma_op_t                  op;
  logic                     op_done;
  logic [31:0]              op_rdata;

  dma_bus_interface #(
    .TABLE_ENTRIES(TABLE_ENTRIES)
  ) u_bus_if (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .wb_req_i   (wbs_req_i),
    .wb_rsp_o   (wbs_rsp_o),
    .field_wr_o (field_wr),
    .done_i     (done)
  );

  dma_request_table #(
    .TABLE_ENTRIES(TABLE_ENTRIES)
  ) u_table (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .field_wr_i     (field_wr),
    .done_o         (done),
    .pend_o         (pend),
    .pend_idx_o     (pend_idx),
    .pend_req_o     (pend_req),
    .complete_i     (complete),
    .complete_idx_i (complete_idx)
  );

  dma_transfer_engine u_engine (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .pend_i         (pend),
    .pend_idx_i     (pend_idx),
    .pend_req_i     (pend_req),
    .complete_o     (complete),
    .complete_idx_o (complete_idx),
    .irq_o          (irq_o),
    .op_o           (op),
    .op_done_i      (op_done),
    .op_rdata_i     (op_rdata)
  );

  dma_wb_master u_master (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .op_i       (op),
    .op_done_o  (op_done),
    .op_rdata_o (op_rdata),
    .wb_req_o   (wbm_req_o),
    .wb_rsp_i   (wbm_rsp_i)
  );

endmodule

`default_nettype wire

// ==== hdl/dma_transfer_engine.sv ====
// DMA transfer engine
// Takes one pending request, copies its words with a read and a write
// per word, then signals completion and a one-cycle interrupt

`timescale 1ns/1ps
`default_nettype none

module dma_transfer_engine (
  input  wire               clk,
  input  wire               arst_n_i,
  input  wire               pend_i,
  input  dma_pkg::dma_idx_t pend_idx_i,
  input  dma_pkg::dma_req_t pend_req_i,
  output logic              complete_o,
  output dma_pkg::dma_idx_t complete_idx_o,
  output logic              irq_o,
  output dma_pkg::dma_op_t  op_o,
  input  wire               op_done_i,
  input  wire [31:0]        op_rdata_i
);

  import dma_pkg::*;

  dma_eng_state_e state_q;
  dma_eng_state_e state_d;
  dma_req_t       req_q;
  dma_idx_t       idx_q;
  logic [31:0]    data_q;
  logic [15:0]    rem_q;
  logic [15:0]    word_q;
  logic [31:0]    offset;
  logic [31:0]    src_addr;
  logic [31:0]    dst_addr;

  ////////////////////////////////////////////////////////////////////////////
  // Address generation
  ////////////////////////////////////////////////////////////////////////////

  // Word counter to byte offset
  assign offset = {14'b0, word_q, 2'b00};

  always_comb begin
    if (req_q.dir == DIR_LOCAL_TO_REMOTE) begin
      src_addr = req_q.laddr + offset;
      dst_addr = req_q.raddr + offset;
    end else begin
      src_addr = req_q.raddr + offset;
      dst_addr = req_q.laddr + offset;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      ENG_IDLE:  if (pend_i) state_d = ENG_LOAD;
      // Empty request skips the bus entirely
      ENG_LOAD:  state_d = (req_q.size == 16'd0) ? ENG_DONE : ENG_READ;
      ENG_READ:  if (op_done_i) state_d = ENG_WRITE;
      ENG_WRITE: begin
        if (op_done_i) begin
          state_d = (rem_q == 16'd1) ? ENG_DONE : ENG_READ;
        end
      end
      ENG_DONE:  state_d = ENG_IDLE;
      default:   state_d = ENG_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ENG_IDLE;
      rem_q   <= '0;
      word_q  <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == ENG_LOAD) begin
        rem_q  <= req_q.size;
        word_q <= '0;
      end else if (state_q == ENG_WRITE && op_done_i) begin
        rem_q  <= rem_q - 16'd1;
        word_q <= word_q + 16'd1;
      end
    end
  end

  // Request snapshot and read buffer
  always_ff @(posedge clk) begin
    if (state_q == ENG_IDLE && pend_i) begin
      req_q <= pend_req_i;
      idx_q <= pend_idx_i;
    end
    if (state_q == ENG_READ && op_done_i) begin
      data_q <= op_rdata_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////

  // Operation held until the master reports it done
  always_comb begin
    op_o.addr   = src_addr;
    op_o.wdata  = data_q;
    op_o.opcode = OP_READ;
    op_o.req    = 1'b0;
    if (state_q == ENG_READ) begin
      op_o.req = 1'b1;
    end else if (state_q == ENG_WRITE) begin
      op_o.addr   = dst_addr;
      op_o.opcode = OP_WRITE;
      op_o.req    = 1'b1;
    end
  end

  assign complete_o     = (state_q == ENG_DONE);
  assign complete_idx_o = idx_q;
  assign irq_o          = (state_q == ENG_DONE);

endmodule

`default_nettype wire

// ==== hdl/dma_wb_master.sv ====
// DMA bus master
// Runs one single-word Wishbone classic read or write per engine
// operation and reports its end with the returned data

`timescale 1ns/1ps
`default_nettype none

module dma_wb_master (
  input  wire              clk,
  input  wire              arst_n_i,
  input  dma_pkg::dma_op_t op_i,
  output logic             op_done_o,
  output logic [31:0]      op_rdata_o,
  output wb_pkg::wb_req_t  wb_req_o,
  input  wb_pkg::wb_rsp_t  wb_rsp_i
);

  import dma_pkg::*;
  import wb_pkg::*;

  dma_mst_state_e state_q;
  logic           we_q;
  logic [31:0]    adr_q;
  logic [31:0]    dat_q;

  ////////////////////////////////////////////////////////////////////////////
  // Cycle control
  ////////////////////////////////////////////////////////////////////////////

  // BUSY spans the whole classic cycle, cleared on the ack edge
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= MST_IDLE;
    end else begin
      case (state_q)
        MST_IDLE: if (op_i.req) state_q <= MST_BUSY;
        MST_BUSY: if (wb_rsp_i.ack) state_q <= MST_IDLE;
        default:  state_q <= MST_IDLE;
      endcase
    end
  end

  // Address, direction and data held stable for the cycle
  always_ff @(posedge clk) begin
    if (state_q == MST_IDLE && op_i.req) begin
      we_q  <= (op_i.opcode == OP_WRITE);
      adr_q <= op_i.addr;
      dat_q <= op_i.wdata;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bus and engine side
  ////////////////////////////////////////////////////////////////////////////

  assign wb_req_o.cyc = (state_q == MST_BUSY);
  assign wb_req_o.stb = (state_q == MST_BUSY);
  assign wb_req_o.we  = we_q;
  assign wb_req_o.adr = adr_q;
  assign wb_req_o.dat = dat_q;
  assign wb_req_o.sel = WB_SEL_WORD;

  // Done in the ack cycle, engine takes the data on that edge
  assign op_done_o  = (state_q == MST_BUSY) & wb_rsp_i.ack;
  assign op_rdata_o = wb_rsp_i.dat;

endmodule

`default_nettype wire

// ==== tests/dma_bus_chk.sv ====
// DMA bus protocol checker
// Concurrent assertions on the Wishbone slave and master ports of the top

`timescale 1ns/1ps
`default_nettype none

module dma_bus_chk (
  input wire             clk,
  input wire             arst_n_i,
  input wb_pkg::wb_req_t wbs_req_i,
  input wb_pkg::wb_rsp_t wbs_rsp_i,
  input wb_pkg::wb_req_t wbm_req_i,
  input wb_pkg::wb_rsp_t wbm_rsp_i
);

  // Number of failed assertions
  int assert_fails = 0;

  ////////////////////////////////////////////////////////////////////////////
  // Ack width
  ////////////////////////////////////////////////////////////////////////////

  a_wbs_ack_single: assert property (
    @(posedge clk) disable iff (!arst_n_i) wbs_rsp_i.ack |=> !wbs_rsp_i.ack
  ) else begin
    $error("slave port ack high in two consecutive cycles");
    assert_fails++;
  end

  a_wbm_ack_single: assert property (
    @(posedge clk) disable iff (!arst_n_i) wbm_rsp_i.ack |=> !wbm_rsp_i.ack
  ) else begin
    $error("master port ack high in two consecutive cycles");
    assert_fails++;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Request hold and framing
  ////////////////////////////////////////////////////////////////////////////

  // Open request keeps stb and its payload until ack
  a_wbm_hold: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    (wbm_req_i.stb && !wbm_rsp_i.ack) |=>
      (wbm_req_i.stb && $stable(wbm_req_i.adr) && $stable(wbm_req_i.we)
       && $stable(wbm_req_i.dat))
  ) else begin
    $error("master port request changed before ack");
    assert_fails++;
  end

  a_wbm_stb_cyc: assert property (
    @(posedge clk) disable iff (!arst_n_i) !(wbm_req_i.stb && !wbm_req_i.cyc)
  ) else begin
    $error("master port stb high without cyc");
    assert_fails++;
  end

  a_wbs_stb_cyc: assert property (
    @(posedge clk) disable iff (!arst_n_i) !(wbs_req_i.stb && !wbs_req_i.cyc)
  ) else begin
    $error("slave port stb high without cyc");
    assert_fails++;
  end

endmodule

bind dma_top dma_bus_chk u_bus_chk (
  .clk       (clk),
  .arst_n_i  (arst_n_i),
  .wbs_req_i (wbs_req_i),
  .wbs_rsp_i (wbs_rsp_o),
  .wbm_req_i (wbm_req_o),
  .wbm_rsp_i (wbm_rsp_i)
);

`default_nettype wire

// ==== tests/dma_tb.sv ====
// DMA testbench
// Programs descriptors through the slave port from a row table, serves the
// master port with a random-latency memory and checks copies, status and irq

`timescale 1ns/1ps
`default_nettype none

module dma_tb;

  import dma_pkg::*;
  import wb_pkg::*;

  localparam int          TABLE_ENTRIES = 4;
  localparam int          NUM_ROWS      = 8;
  localparam int          ACK_LIMIT     = 50;
  localparam int          POLL_LIMIT    = 200;
  localparam logic [31:0] SEED          = 32'hbed304f1;
  localparam logic [31:0] PATTERN_KEY   = 32'h5a5a0000;

  // One stimulus row; a nonzero exp_irq closes a group of rows
  typedef struct packed {
    logic [7:0]  entry;
    logic [31:0] laddr;
    logic [31:0] raddr;
    logic [15:0] size;
    dma_dir_e    dir;
    logic [7:0]  exp_irq;
  } row_t;

  logic        clk;
  logic        arst_n;
  wb_req_t     wbs_req;
  wb_rsp_t     wbs_rsp;
  wb_req_t     wbm_req;
  wb_rsp_t     wbm_rsp;
  logic        irq;
  row_t        rows [NUM_ROWS];
  logic [31:0] mem [0:16383];
  bit          mem_written [0:16383];
  logic [31:0] wr_log [$];
  int          errors        = 0;
  int          irq_count     = 0;
  int          master_cycles = 0;
  int          irq_base      = 0;
  int          mc_base       = 0;

  dma_top #(
    .TABLE_ENTRIES(TABLE_ENTRIES)
  ) dut (
    .clk       (clk),
    .arst_n_i  (arst_n),
    .wbs_req_i (wbs_req),
    .wbs_rsp_o (wbs_rsp),
    .wbm_req_o (wbm_req),
    .wbm_rsp_i (wbm_rsp),
    .irq_o     (irq)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Count irq pulses as sampled before the edge updates
  always @(posedge clk) begin
    if (irq === 1'b1) begin
      irq_count++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Memory model on the master port
  ////////////////////////////////////////////////////////////////////////////

  // Unwritten words read back as a pattern of their own address
  function automatic logic [31:0] pattern(input logic [31:0] addr);
    return addr ^ PATTERN_KEY;
  endfunction

  function automatic logic [31:0] mem_peek(input logic [31:0] addr);
    if (mem_written[addr[15:2]]) begin
      return mem[addr[15:2]];
    end
    return pattern(addr);
  endfunction

  // Ack after 0 to 3 wait cycles and hold it for one cycle
  initial begin : mem_model
    int unsigned seed_ret;
    int          wait_left;
    seed_ret  = $urandom(SEED);
    wbm_rsp   = '0;
    wait_left = -1;
    forever begin
      @(posedge clk);
      if (wbm_rsp.ack) begin
        wbm_rsp.ack <= 1'b0;
        wait_left = -1;
      end else if (wbm_req.cyc && wbm_req.stb) begin
        if (wait_left < 0) begin
          wait_left = $urandom % 4;
        end
        if (wait_left == 0) begin
          wbm_rsp.ack <= 1'b1;
          master_cycles++;
          // Master drives all byte lanes
          check_equal("wbm_req.sel", wbm_req.sel, 32'hF);
          if (wbm_req.we) begin
            mem[wbm_req.adr[15:2]]         = wbm_req.dat;
            mem_written[wbm_req.adr[15:2]] = 1'b1;
            wr_log.push_back(wbm_req.adr);
          end else begin
            wbm_rsp.dat <= mem_peek(wbm_req.adr);
          end
          wait_left = -1;
        end else begin
          wait_left--;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks and run control
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_equal(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_and_finish();
    int fails;
    fails = dut.u_bus_chk.assert_fails;
    $display("Run ended at %0t ns: %0d check errors, %0d assertion failures",
             $time, errors, fails);
    if (errors == 0 && fails == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  endtask

  task automatic abort_timeout(input string what);
    errors++;
    $display("Timeout at %0t ns: %s did not respond in time", $time, what);
    report_and_finish();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Slave port access
  ////////////////////////////////////////////////////////////////////////////

  // Entry in address bits 12:5 and field offset in 4:0
  function automatic logic [31:0] reg_addr(input logic [7:0] entry, input dma_field_e field);
    return {19'b0, entry, field};
  endfunction

  // One classic cycle dropped on the edge that sees ack
  task automatic slave_access(input logic we, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
    int cycles;
    cycles = 0;
    @(posedge clk);
    wbs_req <= {1'b1, 1'b1, we, addr, wdata, 4'hF};
    @(posedge clk);
    while (!wbs_rsp.ack && cycles < ACK_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    if (!wbs_rsp.ack) begin
      abort_timeout("slave ack");
    end else begin
      rdata = wbs_rsp.dat;
      wbs_req <= '0;
    end
  endtask

  task automatic wait_status_done(input logic [7:0] entry);
    logic [31:0] rdata;
    int          polls;
    polls = 0;
    rdata = '0;
    while (rdata[0] !== 1'b1 && polls < POLL_LIMIT) begin
      slave_access(1'b0, reg_addr(entry, FIELD_STATUS), 32'h0, rdata);
      polls++;
    end
    if (rdata[0] !== 1'b1) begin
      abort_timeout($sformatf("status of entry %0d", entry));
    end else begin
      // Done bit only with the upper bits zero
      check_equal($sformatf("status[%0d]", entry), rdata, 32'h1);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Row handling
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] src_base(input row_t r);
    return (r.dir == DIR_LOCAL_TO_REMOTE) ? r.laddr : r.raddr;
  endfunction

  function automatic logic [31:0] dst_base(input row_t r);
    return (r.dir == DIR_LOCAL_TO_REMOTE) ? r.raddr : r.laddr;
  endfunction

  function automatic logic in_dest(input logic [31:0] addr, input int first, input int last);
    logic hit;
    hit = 1'b0;
    for (int r = first; r <= last; r++) begin
      if (addr >= dst_base(rows[r]) && addr < dst_base(rows[r]) + 32'(rows[r].size) * 4) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  // Fields first and arm last; a fresh arm reads back not done
  task automatic program_row(input row_t r);
    logic [31:0] rdata;
    slave_access(1'b1, reg_addr(r.entry, FIELD_LADDR), r.laddr, rdata);
    slave_access(1'b1, reg_addr(r.entry, FIELD_SIZE), {16'b0, r.size}, rdata);
    slave_access(1'b1, reg_addr(r.entry, FIELD_RADDR), r.raddr, rdata);
    slave_access(1'b1, reg_addr(r.entry, FIELD_CTRL), {31'b0, r.dir}, rdata);
    slave_access(1'b1, reg_addr(r.entry, FIELD_STATUS), 32'h1, rdata);
    slave_access(1'b0, reg_addr(r.entry, FIELD_STATUS), 32'h0, rdata);
    check_equal($sformatf("status[%0d] after arm", r.entry), rdata, 32'h0);
  endtask

  // Completion, copied words, irq pulses and bus traffic of one group
  task automatic check_group(input int first, input int last);
    int          r;
    int          w;
    int unsigned words;
    logic [31:0] src;
    logic [31:0] dst;
    words = 0;
    for (r = first; r <= last; r++) begin
      wait_status_done(rows[r].entry);
    end
    for (r = first; r <= last; r++) begin
      words += rows[r].size;
      src = src_base(rows[r]);
      dst = dst_base(rows[r]);
      for (w = 0; w < rows[r].size; w++) begin
        check_equal($sformatf("mem[%h]", dst + 32'(4 * w)), mem_peek(dst + 32'(4 * w)),
                    pattern(src + 32'(4 * w)));
      end
    end
    check_equal("irq_o pulses", irq_count - irq_base, rows[last].exp_irq);
    check_equal("master cycles", master_cycles - mc_base, 2 * words);
    check_equal("master writes", wr_log.size(), words);
    foreach (wr_log[k]) begin
      check_equal($sformatf("write %h in dest range", wr_log[k]),
                  in_dest(wr_log[k], first, last), 32'h1);
    end
    irq_base = irq_count;
    mc_base  = master_cycles;
    wr_log.delete();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main
    logic [31:0] rdata;
    int          e;
    int          i;
    int          grp_first;
    arst_n  = 1'b0;
    wbs_req = '0;
    // Single copies then four back to back, a size zero entry and a same-entry re-arm
    rows[0] = '{8'd0, 32'h1000, 32'h8000, 16'd4, DIR_REMOTE_TO_LOCAL, 8'd1};
    rows[1] = '{8'd1, 32'h2000, 32'h9000, 16'd5, DIR_LOCAL_TO_REMOTE, 8'd1};
    rows[2] = '{8'd0, 32'h3000, 32'hA000, 16'd3, DIR_LOCAL_TO_REMOTE, 8'd0};
    rows[3] = '{8'd1, 32'h3100, 32'hA100, 16'd2, DIR_REMOTE_TO_LOCAL, 8'd0};
    rows[4] = '{8'd2, 32'h3200, 32'hA200, 16'd6, DIR_LOCAL_TO_REMOTE, 8'd0};
    rows[5] = '{8'd3, 32'h3300, 32'hA300, 16'd1, DIR_REMOTE_TO_LOCAL, 8'd4};
    rows[6] = '{8'd2, 32'h4000, 32'hB000, 16'd0, DIR_REMOTE_TO_LOCAL, 8'd1};
    rows[7] = '{8'd3, 32'h3400, 32'hA400, 16'd1, DIR_REMOTE_TO_LOCAL, 8'd1};
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);
    check_equal("irq_o", irq, 32'h0);
    check_equal("wbs_rsp.ack", wbs_rsp.ack, 32'h0);
    check_equal("wbm_req.cyc", wbm_req.cyc, 32'h0);
    for (e = 0; e < TABLE_ENTRIES; e++) begin
      slave_access(1'b0, reg_addr(8'(e), FIELD_STATUS), 32'h0, rdata);
      check_equal($sformatf("status[%0d] after reset", e), rdata, 32'h0);
    end
    // Descriptor fields other than status read as zero
    slave_access(1'b0, reg_addr(8'd0, FIELD_LADDR), 32'h0, rdata);
    check_equal("laddr[0] readback", rdata, 32'h0);
    irq_base  = irq_count;
    mc_base   = master_cycles;
    grp_first = 0;
    for (i = 0; i < NUM_ROWS; i++) begin
      program_row(rows[i]);
      if (rows[i].exp_irq != 0) begin
        check_group(grp_first, i);
        grp_first = i + 1;
      end
    end
    repeat (4) @(posedge clk);
    report_and_finish();
  end

endmodule

`default_nettype wire
